//--- hdl/ps2_key_pkg.sv
package ps2_key_pkg;

    // PS/2 frame: start, 8 data bits LSB first, odd parity, stop
    localparam int FRAME_BITS = 11;
    localparam int BIT_IDX_W = $clog2(FRAME_BITS);

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);

    // idle clocks allowed inside a frame before it is thrown away
    localparam int WATCHDOG_CYCLES = 1023;
    localparam int WD_W = $clog2(WATCHDOG_CYCLES + 1);

    localparam logic [7:0] BREAK_CODE = 8'hF0;    // release prefix

    localparam logic SEG_BLANK_DP = 1'b1;         // segments are active low

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_POP,
        DEC_MAKE,
        DEC_BREAK
    } dec_state_t;

    // active-low seven-segment pattern, bit order gfedcba
    function automatic logic [6:0] hex_to_seg(input logic [3:0] nib);
        logic [6:0] seg;
        case (nib)
            4'h0: seg = 7'h40;
            4'h1: seg = 7'h79;
            4'h2: seg = 7'h24;
            4'h3: seg = 7'h30;
            4'h4: seg = 7'h19;
            4'h5: seg = 7'h12;
            4'h6: seg = 7'h02;
            4'h7: seg = 7'h78;
            4'h8: seg = 7'h00;
            4'h9: seg = 7'h10;
            4'hA: seg = 7'h08;
            4'hB: seg = 7'h03;
            4'hC: seg = 7'h46;
            4'hD: seg = 7'h21;
            4'hE: seg = 7'h06;
            default: seg = 7'h0E;
        endcase
        return seg;
    endfunction

endpackage

//--- hdl/ps2_rx.sv
`timescale 1ns/10ps

module ps2_rx
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] rx_byte,
    output logic       rx_strobe
);

    import ps2_key_pkg::*;

    logic [2:0]            clk_ff;    // two sync stages plus one for edge detect
    logic [1:0]            dat_ff;
    logic                  ps2_fall;
    logic                  dat_s;
    logic [FRAME_BITS-1:0] frame;
    logic [FRAME_BITS-1:0] next_frame;
    logic [BIT_IDX_W-1:0]  bit_idx;
    logic [WD_W-1:0]       wd_cnt;
    logic                  last_bit;
    logic                  frame_ok;
    logic                  wd_expired;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_ff <= 3'b111;                 // lines idle high
            dat_ff <= 2'b11;
        end
        else
        begin
            clk_ff <= {clk_ff[1:0], ps2_clk};
            dat_ff <= {dat_ff[0], ps2_dat};
        end
    end

    assign ps2_fall = clk_ff[2] & ~clk_ff[1];
    assign dat_s = dat_ff[1];

    // bits arrive LSB first, so shift in from the top
    assign next_frame = {dat_s, frame[FRAME_BITS-1:1]};
    assign last_bit = (bit_idx == BIT_IDX_W'(FRAME_BITS - 1));

    // start low, stop high, odd parity over data and parity bit
    assign frame_ok = (next_frame[0] == 1'b0) &&
                      (next_frame[FRAME_BITS-1] == 1'b1) &&
                      (^next_frame[9:1] == 1'b1);

    assign wd_expired = (wd_cnt == WD_W'(WATCHDOG_CYCLES));

    always_ff @(posedge clk)
    begin
        if (ps2_fall)
        begin
            frame <= next_frame;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            bit_idx <= '0;
            wd_cnt <= '0;
        end
        else if (ps2_fall)
        begin
            wd_cnt <= '0;
            if (last_bit)
            begin
                bit_idx <= '0;
            end
            else
            begin
                bit_idx <= bit_idx + 1'b1;
            end
        end
        else if (bit_idx != '0)
        begin
            // keyboard went quiet mid-frame
            if (wd_expired)
            begin
                wd_cnt <= '0;
                bit_idx <= '0;
            end
            else
            begin
                wd_cnt <= wd_cnt + 1'b1;
            end
        end
        else
        begin
            wd_cnt <= '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            rx_strobe <= 1'b0;
        end
        else
        begin
            rx_strobe <= ps2_fall && last_bit && frame_ok;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ps2_fall && last_bit)
        begin
            rx_byte <= next_frame[8:1];
        end
    end

endmodule

//--- hdl/scan_fifo.sv
`timescale 1ns/10ps

module scan_fifo
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] wr_data,
    input  logic       wr_en,
    input  logic       nextdata_n,
    output logic [7:0] data,
    output logic       ready
);

    import ps2_key_pkg::*;

    logic [7:0]       mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               pop;
    logic               full;

    assign pop = ~nextdata_n;
    assign full = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign ready = (count != '0);
    assign data = mem[rd_ptr];            // oldest byte

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the link is far slower than the decoder, so the buffer never fills
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst) wr_en |-> !full)
        else $error("scan_fifo write while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst) pop |-> ready)
        else $error("scan_fifo pop while empty");

endmodule

//--- hdl/key_decoder.sv
`timescale 1ns/10ps

module key_decoder
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ready,
    input  logic [7:0] data,
    output logic       nextdata_n,
    output logic [7:0] key_code,
    output logic       key_valid
);

    import ps2_key_pkg::*;

    dec_state_t state;
    logic [7:0] byte_r;        // byte taken during the pop
    logic       brk_flag;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state <= DEC_IDLE;
            nextdata_n <= 1'b1;
        end
        else
        begin
            nextdata_n <= 1'b1;
            case (state)
                DEC_IDLE:
                begin
                    if (ready)
                    begin
                        state <= DEC_POP;
                        nextdata_n <= 1'b0;   // low during the pop cycle
                    end
                end
                DEC_POP:
                begin
                    if (data == BREAK_CODE)
                    begin
                        state <= DEC_BREAK;
                    end
                    else
                    begin
                        state <= DEC_MAKE;
                    end
                end
                default: state <= DEC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == DEC_POP)
        begin
            byte_r <= data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            brk_flag <= 1'b0;
            key_code <= 8'h00;
            key_valid <= 1'b0;
        end
        else
        begin
            key_valid <= 1'b0;
            if (state == DEC_BREAK)
            begin
                brk_flag <= 1'b1;
            end
            else if (state == DEC_MAKE && brk_flag)
            begin
                // byte after F0 is the released key
                key_code <= byte_r;
                key_valid <= 1'b1;
                brk_flag <= 1'b0;
            end
        end
    end

    a_valid_after_break: assert property (@(posedge clk) disable iff (!rst)
        $rose(key_valid) |-> $past(state == DEC_MAKE && brk_flag))
        else $error("key_valid without a preceding break");

endmodule

//--- hdl/hex_display.sv
`timescale 1ns/10ps

module hex_display
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] key_code,
    output logic [7:0] seg1,
    output logic [7:0] seg2
);

    import ps2_key_pkg::*;

    logic [6:0] lo_pat;
    logic [6:0] hi_pat;

    assign lo_pat = hex_to_seg(key_code[3:0]);
    assign hi_pat = hex_to_seg(key_code[7:4]);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            // show 00 out of reset
            seg1 <= {SEG_BLANK_DP, hex_to_seg(4'h0)};
            seg2 <= {SEG_BLANK_DP, hex_to_seg(4'h0)};
        end
        else
        begin
            seg1 <= {SEG_BLANK_DP, lo_pat};   // low nibble
            seg2 <= {SEG_BLANK_DP, hi_pat};
        end
    end

endmodule

//--- hdl/ps2_key_top.sv
`timescale 1ns/10ps

module ps2_key_top
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] seg1,
    output logic [7:0] seg2,
    output logic [7:0] key_code,
    output logic       key_valid
);

    logic [7:0] rx_byte;
    logic       rx_strobe;
    logic [7:0] fifo_data;
    logic       fifo_ready;
    logic       nextdata_n;

    ps2_rx u_rx
    (
        .clk       (clk),
        .rst       (rst),
        .ps2_clk   (ps2_clk),
        .ps2_dat   (ps2_dat),
        .rx_byte   (rx_byte),
        .rx_strobe (rx_strobe)
    );

    scan_fifo u_fifo
    (
        .clk        (clk),
        .rst        (rst),
        .wr_data    (rx_byte),
        .wr_en      (rx_strobe),
        .nextdata_n (nextdata_n),
        .data       (fifo_data),
        .ready      (fifo_ready)
    );

    key_decoder u_dec
    (
        .clk        (clk),
        .rst        (rst),
        .ready      (fifo_ready),
        .data       (fifo_data),
        .nextdata_n (nextdata_n),
        .key_code   (key_code),
        .key_valid  (key_valid)
    );

    hex_display u_disp
    (
        .clk      (clk),
        .rst      (rst),
        .key_code (key_code),
        .seg1     (seg1),
        .seg2     (seg2)
    );

endmodule

//--- tb/ps2_key_tb.sv
`timescale 1ns/10ps

module ps2_key_tb;

    localparam int CLK_HALF = 2;
    localparam int RESET_CYCLES = 5;
    localparam int BIT_CYCLES = 40;        // one ps2 bit in system clocks
    localparam int FRAME_LEN = 11;
    localparam int FRAME_GAP = 40;
    localparam int WD_IDLE = 1100;         // longer than the receiver watchdog
    localparam int QUIET_CYCLES = 2000;
    localparam int NUM_ROWS = 10;
    localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + WD_IDLE +
        NUM_ROWS * (3 * (FRAME_LEN * BIT_CYCLES + FRAME_GAP) + QUIET_CYCLES + 2));
    localparam logic [31:0] SEED = 32'h48702776;
    localparam logic [7:0] BREAK_BYTE = 8'hF0;

    logic       clk;
    logic       rst;
    logic       ps2_clk;
    logic       ps2_dat;
    logic [7:0] seg1;
    logic [7:0] seg2;
    logic [7:0] key_code;
    logic       key_valid;

    // stimulus table with one row per test
    int         row_len   [NUM_ROWS];
    logic [7:0] row_byte  [NUM_ROWS][3];
    logic       row_bad   [NUM_ROWS][3];
    logic       row_cut   [NUM_ROWS][3];
    logic       row_valid [NUM_ROWS];
    logic [7:0] row_code  [NUM_ROWS];

    int err_cnt = 0;
    int valid_cnt = 0;
    int cycles = 0;

    ps2_key_top UUT
    (
        .clk       (clk),
        .rst       (rst),
        .ps2_clk   (ps2_clk),
        .ps2_dat   (ps2_dat),
        .seg1      (seg1),
        .seg2      (seg2),
        .key_code  (key_code),
        .key_valid (key_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #CLK_HALF clk = ~clk;
        end
    end

    always @(negedge clk)
    begin
        if (rst && key_valid)
        begin
            valid_cnt <= valid_cnt + 1;
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // active-low gfedcba with the decimal point off
    function automatic logic [7:0] seg_expected(input logic [3:0] nib);
        logic [7:0] pat;
        case (nib)
            4'h0: pat = 8'hC0;
            4'h1: pat = 8'hF9;
            4'h2: pat = 8'hA4;
            4'h3: pat = 8'hB0;
            4'h4: pat = 8'h99;
            4'h5: pat = 8'h92;
            4'h6: pat = 8'h82;
            4'h7: pat = 8'hF8;
            4'h8: pat = 8'h80;
            4'h9: pat = 8'h90;
            4'hA: pat = 8'h88;
            4'hB: pat = 8'h83;
            4'hC: pat = 8'hC6;
            4'hD: pat = 8'hA1;
            4'hE: pat = 8'h86;
            default: pat = 8'h8E;
        endcase
        return pat;
    endfunction

    function automatic logic [7:0] random_key();
        logic [7:0] b;
        b = 8'($urandom);
        while (b == BREAK_BYTE)
        begin
            b = 8'($urandom);
        end
        return b;
    endfunction

    task automatic check_value(input string what, input logic [7:0] got,
                               input logic [7:0] exp);
        if (got !== exp)
        begin
            $display("Error at %0d ns: %s is %02h, expected %02h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic set_row(input int idx, input int len, input logic [7:0] b0,
                           input logic [7:0] b1, input logic [7:0] b2,
                           input logic [2:0] bad, input logic [2:0] cut,
                           input logic valid, input logic [7:0] code);
        row_len[idx] = len;
        row_byte[idx][0] = b0;
        row_byte[idx][1] = b1;
        row_byte[idx][2] = b2;
        for (int k = 0; k < 3; k++)
        begin
            row_bad[idx][k] = bad[k];
            row_cut[idx][k] = cut[k];
        end
        row_valid[idx] = valid;
        row_code[idx] = code;
    endtask

    task automatic load_table();
        logic [7:0] rk;
        set_row(0, 0, 8'h00, 8'h00, 8'h00, 3'b000, 3'b000, 1'b0, 8'h00);  // reset state
        set_row(1, 3, 8'h1C, BREAK_BYTE, 8'h1C, 3'b000, 3'b000, 1'b1, 8'h1C);
        set_row(2, 1, 8'h23, 8'h00, 8'h00, 3'b000, 3'b000, 1'b0, 8'h1C);   // make only
        set_row(3, 3, BREAK_BYTE, 8'h5A, 8'h2B, 3'b010, 3'b000, 1'b1, 8'h2B);
        set_row(4, 3, 8'h3A, BREAK_BYTE, 8'h4B, 3'b000, 3'b001, 1'b1, 8'h4B);
        for (int i = 5; i < NUM_ROWS; i++)
        begin
            rk = random_key();
            set_row(i, 3, rk, BREAK_BYTE, rk, 3'b000, 3'b000, 1'b1, rk);
        end
    endtask

    // data changes while ps2_clk is high and the host samples on the fall
    task automatic send_frame(input logic [7:0] code, input logic bad_par,
                              input logic cut);
        logic [10:0] bits;
        int n_bits;
        bits = {1'b1, (~^code) ^ bad_par, code, 1'b0};
        n_bits = cut ? 5 : FRAME_LEN;
        for (int i = 0; i < n_bits; i++)
        begin
            @(posedge clk);
            ps2_dat <= bits[i];
            repeat (BIT_CYCLES / 4) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (BIT_CYCLES / 2) @(posedge clk);
            ps2_clk <= 1'b1;
            repeat (BIT_CYCLES / 4 - 1) @(posedge clk);
        end
        @(posedge clk);
        ps2_dat <= 1'b1;
        repeat (FRAME_GAP) @(posedge clk);
    endtask

    initial
    begin
        int wait_cnt;
        int start_cnt;
        int err_before;
        int failed_tests;
        void'($urandom(SEED));
        failed_tests = 0;
        rst = 1'b0;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;
        repeat (4) @(posedge clk);

        for (int row = 0; row < NUM_ROWS; row++)
        begin
            err_before = err_cnt;
            start_cnt = valid_cnt;
            for (int k = 0; k < row_len[row]; k++)
            begin
                send_frame(row_byte[row][k], row_bad[row][k], row_cut[row][k]);
                if (row_cut[row][k])
                begin
                    repeat (WD_IDLE) @(posedge clk);   // let the watchdog fire
                end
            end
            wait_cnt = 0;
            while (valid_cnt == start_cnt && wait_cnt < QUIET_CYCLES)
            begin
                @(negedge clk);
                wait_cnt++;
            end
            if (row_valid[row] && valid_cnt == start_cnt)
            begin
                $display("test %0d: key_valid never arrived within %0d cycles",
                         row, QUIET_CYCLES);
                err_cnt++;
            end
            else if (!row_valid[row] && valid_cnt != start_cnt)
            begin
                $display("test %0d: key_valid pulsed although no key was released", row);
                err_cnt++;
            end
            check_value("key_code", key_code, row_code[row]);
            @(negedge clk);
            check_value("seg1", seg1, seg_expected(row_code[row][3:0]));
            check_value("seg2", seg2, seg_expected(row_code[row][7:4]));
            if (row_valid[row] && valid_cnt - start_cnt > 1)
            begin
                $display("test %0d: more than one key_valid pulse", row);
                err_cnt++;
            end
            if (err_cnt != err_before)
            begin
                failed_tests++;
            end
            $display("test %0d: key %02h %s", row, row_code[row],
                     (err_cnt == err_before) ? "ok" : "FAILED");
        end

        $display("%0d tests run, %0d failed, %0d errors", NUM_ROWS, failed_tests, err_cnt);
        if (err_cnt == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- ps2_key.f
hdl/ps2_key_pkg.sv
hdl/ps2_rx.sv
hdl/scan_fifo.sv
hdl/key_decoder.sv
hdl/hex_display.sv
hdl/ps2_key_top.sv
tb/ps2_key_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TB_TOP     = ps2_key_tb
RTL_TOP    = ps2_key_top
FILELIST   = ps2_key.f
BUILD_DIR  = obj_dir
LOG        = sim.log
COMMON     = --timing --timescale 1ns/10ps
LINT_FLAGS = --lint-only $(COMMON)
SIM_FLAGS  = --binary --assert $(COMMON) -Wno-fatal -Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
